// File: rtl/n64_ppu_pkg.sv
`default_nettype none

package n64_ppu_pkg;

  // ==============================
  // widths
  // ==============================
  localparam int COLOR_W_I = 7;  // per channel on the N64 bus
  localparam int COLOR_W_O = 8;

  typedef logic [COLOR_W_I-1:0] vd_in_t;
  typedef logic [COLOR_W_O-1:0] color_t;
  typedef logic [9:0]           line_cnt_t;  // enough for 625 line sources
  typedef logic [7:0]           sl_str_t;

  // ==============================
  // pixel and config words
  // ==============================
  typedef struct packed {
    logic   vsync;  // decoded, active high
    logic   hsync;
    logic   valid;  // one-cycle strobe per pixel
    color_t r;
    color_t g;
    color_t b;
  } pixel_t;

  typedef struct packed {
    logic       sl_en;
    logic [3:0] sl_str;        // widened to sl_str_t in the decoder
    logic       color_16bit;
    logic       active_vsync;  // 1 = high-active output
    logic       active_hsync;
    logic [7:0] reserved;
  } ppu_cfg_t;

  typedef struct packed {
    logic vdata_detected;
    logic palmode;
    logic n64_480i;
  } ppu_status_t;

  // which word the bus carries next
  typedef enum logic [1:0] {
    SYNC,
    RED,
    GREEN,
    BLUE
  } demux_phase_e;

endpackage

`default_nettype wire

// File: rtl/n64_vdemux.sv
`timescale 1ns/1ps
`default_nettype none

module n64_vdemux (
  input  wire                      N64_CLK_i,
  input  wire                      rst_i,
  input  wire                      nVDSYNC_i,
  input  wire n64_ppu_pkg::vd_in_t VD_i,
  input  wire                      color_16bit_i,
  output n64_ppu_pkg::pixel_t      pix_o
);

  localparam int MSB = n64_ppu_pkg::COLOR_W_I - 1;

  n64_ppu_pkg::vd_in_t       vd_q;
  logic                      nvdsync_q;
  n64_ppu_pkg::demux_phase_e phase_q;
  n64_ppu_pkg::vd_in_t       r_q;  // held until blue arrives
  n64_ppu_pkg::vd_in_t       g_q;
  logic                      vsync_q;
  logic                      hsync_q;
  logic                      valid_q;
  n64_ppu_pkg::color_t       r_o;
  n64_ppu_pkg::color_t       g_o;
  n64_ppu_pkg::color_t       b_o;

  // 7 to 8 bit, msb repeated below the lsb
  function automatic n64_ppu_pkg::color_t expand(
    input n64_ppu_pkg::vd_in_t c,
    input logic                mode16
  );
    n64_ppu_pkg::vd_in_t c_m;
    c_m = mode16 ? {c[MSB:2], 2'b00} : c;  // 16 bit mode drops two lsbs
    return {c_m, c_m[MSB]};
  endfunction

  // ==============================
  // bus capture
  // ==============================
  always_ff @(posedge N64_CLK_i) begin
    vd_q <= VD_i;
    if (rst_i) begin
      nvdsync_q <= 1'b1;
    end else begin
      nvdsync_q <= nVDSYNC_i;
    end
  end

  // ==============================
  // phase fsm and sync flags
  // ==============================
  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      phase_q <= n64_ppu_pkg::SYNC;
      valid_q <= 1'b0;
      vsync_q <= 1'b0;
      hsync_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (!nvdsync_q) begin
        phase_q <= n64_ppu_pkg::RED;  // any sync word restarts the triple
        vsync_q <= ~vd_q[3];
        hsync_q <= ~vd_q[1];
      end else begin
        case (phase_q)
          n64_ppu_pkg::RED:   phase_q <= n64_ppu_pkg::GREEN;
          n64_ppu_pkg::GREEN: phase_q <= n64_ppu_pkg::BLUE;
          n64_ppu_pkg::BLUE: begin
            phase_q <= n64_ppu_pkg::SYNC;
            valid_q <= 1'b1;
          end
          default: phase_q <= n64_ppu_pkg::SYNC;  // stray data, wait for sync
        endcase
      end
    end
  end

  // colour payload
  always_ff @(posedge N64_CLK_i) begin
    if (nvdsync_q) begin
      case (phase_q)
        n64_ppu_pkg::RED:   r_q <= vd_q;
        n64_ppu_pkg::GREEN: g_q <= vd_q;
        n64_ppu_pkg::BLUE: begin
          r_o <= expand(r_q, color_16bit_i);
          g_o <= expand(g_q, color_16bit_i);
          b_o <= expand(vd_q, color_16bit_i);
        end
        default: ;
      endcase
    end
  end

  assign pix_o = '{vsync: vsync_q, hsync: hsync_q, valid: valid_q, r: r_o, g: g_o, b: b_o};

  // a full sync + rgb group lies between two pixels
  a_valid_single: assert property (@(posedge N64_CLK_i) disable iff (rst_i)
    pix_o.valid |=> !pix_o.valid);

endmodule

`default_nettype wire

// File: rtl/n64_vinfo.sv
`timescale 1ns/1ps
`default_nettype none

module n64_vinfo #(
  parameter int PAL_LINE_THRESHOLD = 288
) (
  input  wire                      N64_CLK_i,
  input  wire                      rst_i,
  input  wire n64_ppu_pkg::pixel_t pix_i,
  output n64_ppu_pkg::ppu_status_t status_o
);

  logic                   vsync_d;
  logic                   hsync_d;
  logic                   vs_rise;
  logic                   hs_rise;
  n64_ppu_pkg::line_cnt_t line_cnt;
  logic                   prev_lsb;  // lsb of last frame's count
  logic [1:0]             vs_seen;   // saturates at two

  assign vs_rise = pix_i.vsync & ~vsync_d;
  assign hs_rise = pix_i.hsync & ~hsync_d;

  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      vsync_d <= 1'b0;
      hsync_d <= 1'b0;
    end else begin
      vsync_d <= pix_i.vsync;
      hsync_d <= pix_i.hsync;
    end
  end

  // ==============================
  // lines per frame
  // ==============================
  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      line_cnt <= '0;
    end else if (vs_rise) begin
      line_cnt <= '0;
    end else if (hs_rise && line_cnt != '1) begin
      line_cnt <= line_cnt + 1'b1;
    end
  end

  // ==============================
  // status at each vsync
  // ==============================
  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      status_o <= '0;
      prev_lsb <= 1'b0;
      vs_seen  <= 2'd0;
    end else if (vs_rise) begin
      prev_lsb <= line_cnt[0];
      if (vs_seen != 2'd2) begin
        vs_seen <= vs_seen + 2'd1;
      end
      // first vsync only closes a partial frame
      if (vs_seen != 2'd0) begin
        status_o.vdata_detected <= 1'b1;
        status_o.palmode        <= int'(line_cnt) > PAL_LINE_THRESHOLD;
      end
      if (vs_seen == 2'd2) begin
        status_o.n64_480i <= line_cnt[0] ^ prev_lsb;  // odd/even field pairs
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/ppu_cfg_decode.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_cfg_decode (
  input  wire                        N64_CLK_i,
  input  wire                        rst_i,
  input  wire n64_ppu_pkg::ppu_cfg_t cfg_i,
  input  wire                        n64_480i_i,
  output logic                       sl_en_o,
  output n64_ppu_pkg::sl_str_t       sl_str_o,
  output logic                       color_16bit_o,
  output logic                       active_vsync_o,
  output logic                       active_hsync_o
);

  n64_ppu_pkg::sl_str_t sl_str_w;

  // (setting + 1) * 16 - 1, 0 -> 15 and 15 -> 255
  assign sl_str_w = ((n64_ppu_pkg::sl_str_t'(cfg_i.sl_str) + 8'd1) << 4) - 8'd1;

  // ==============================
  // registered settings
  // ==============================
  always_ff @(posedge N64_CLK_i) begin
    active_vsync_o <= cfg_i.active_vsync;
    active_hsync_o <= cfg_i.active_hsync;
    sl_str_o       <= sl_str_w;
    if (rst_i) begin
      sl_en_o       <= 1'b0;
      color_16bit_o <= 1'b0;
    end else begin
      sl_en_o       <= cfg_i.sl_en & ~n64_480i_i;  // no scanlines on interlaced input
      color_16bit_o <= cfg_i.color_16bit;
    end
  end

endmodule

`default_nettype wire

// File: rtl/scanline_emu.sv
`timescale 1ns/1ps
`default_nettype none

module scanline_emu (
  input  wire                       N64_CLK_i,
  input  wire                       rst_i,
  input  wire                       sl_en_i,
  input  wire n64_ppu_pkg::sl_str_t sl_str_i,
  input  wire n64_ppu_pkg::pixel_t  pix_i,
  output n64_ppu_pkg::pixel_t       pix_o
);

  localparam int PROD_W = n64_ppu_pkg::COLOR_W_O + $bits(n64_ppu_pkg::sl_str_t);

  logic vsync_d;
  logic hsync_d;
  logic odd_line;
  logic darken;

  // c - c * s / 256, truncated
  function automatic n64_ppu_pkg::color_t dim(
    input n64_ppu_pkg::color_t  c,
    input n64_ppu_pkg::sl_str_t s
  );
    logic [PROD_W-1:0] prod;
    prod = c * s;
    return c - n64_ppu_pkg::color_t'(prod >> $bits(n64_ppu_pkg::sl_str_t));
  endfunction

  // ==============================
  // line parity
  // ==============================
  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      vsync_d  <= 1'b0;
      hsync_d  <= 1'b0;
      odd_line <= 1'b0;
    end else begin
      vsync_d <= pix_i.vsync;
      hsync_d <= pix_i.hsync;
      if (pix_i.vsync && !vsync_d) begin
        odd_line <= 1'b0;  // first line of a frame is even
      end else if (pix_i.hsync && !hsync_d) begin
        odd_line <= ~odd_line;
      end
    end
  end

  assign darken = sl_en_i & odd_line & pix_i.valid;

  // ==============================
  // output stage
  // ==============================
  always_ff @(posedge N64_CLK_i) begin
    pix_o.r <= darken ? dim(pix_i.r, sl_str_i) : pix_i.r;
    pix_o.g <= darken ? dim(pix_i.g, sl_str_i) : pix_i.g;
    pix_o.b <= darken ? dim(pix_i.b, sl_str_i) : pix_i.b;
    if (rst_i) begin
      pix_o.vsync <= 1'b0;
      pix_o.hsync <= 1'b0;
      pix_o.valid <= 1'b0;
    end else begin
      pix_o.vsync <= pix_i.vsync;
      pix_o.hsync <= pix_i.hsync;
      pix_o.valid <= pix_i.valid;
    end
  end

  // scanlines only ever darken
  a_no_brighten: assert property (@(posedge N64_CLK_i) disable iff (rst_i)
    pix_o.valid |-> (pix_o.r <= $past(pix_i.r)) && (pix_o.g <= $past(pix_i.g))
                    && (pix_o.b <= $past(pix_i.b)));

endmodule

`default_nettype wire

// File: rtl/video_out.sv
`timescale 1ns/1ps
`default_nettype none

module video_out (
  input  wire                                 N64_CLK_i,
  input  wire                                 rst_i,
  input  wire                                 active_vsync_i,
  input  wire                                 active_hsync_i,
  input  wire n64_ppu_pkg::pixel_t            pix_i,
  output logic                                VSYNC_o,
  output logic                                HSYNC_o,
  output logic                                DE_o,
  output logic [3*n64_ppu_pkg::COLOR_W_O-1:0] VD_o
);

  logic de_w;

  assign de_w = pix_i.valid & ~pix_i.vsync & ~pix_i.hsync;  // blank during sync

  // ==============================
  // final registers
  // ==============================
  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      VSYNC_o <= ~active_vsync_i;  // idle level
      HSYNC_o <= ~active_hsync_i;
      DE_o    <= 1'b0;
      VD_o    <= '0;
    end else begin
      VSYNC_o <= pix_i.vsync ? active_vsync_i : ~active_vsync_i;
      HSYNC_o <= pix_i.hsync ? active_hsync_i : ~active_hsync_i;
      DE_o    <= de_w;
      VD_o    <= de_w ? {pix_i.r, pix_i.g, pix_i.b} : '0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/n64_ppu_top.sv
`timescale 1ns/1ps
`default_nettype none

module n64_ppu_top #(
  parameter int PAL_LINE_THRESHOLD = 288
) (
  input  wire                                 N64_CLK_i,
  input  wire                                 rst_i,
  input  wire                                 nVDSYNC_i,
  input  wire n64_ppu_pkg::vd_in_t            VD_i,
  input  wire n64_ppu_pkg::ppu_cfg_t          ConfigSet_i,
  output n64_ppu_pkg::ppu_status_t            PPUState_o,
  output logic                                VSYNC_o,
  output logic                                HSYNC_o,
  output logic                                DE_o,
  output logic [3*n64_ppu_pkg::COLOR_W_O-1:0] VD_o
);

  wire n64_ppu_pkg::pixel_t  demux_pix;
  wire n64_ppu_pkg::pixel_t  sl_pix;
  wire                       sl_en;
  wire n64_ppu_pkg::sl_str_t sl_str;
  wire                       color_16bit;
  wire                       active_vsync;
  wire                       active_hsync;

  // ==============================
  // input side
  // ==============================
  n64_vdemux u_vdemux (
    .N64_CLK_i     (N64_CLK_i),
    .rst_i         (rst_i),
    .nVDSYNC_i     (nVDSYNC_i),
    .VD_i          (VD_i),
    .color_16bit_i (color_16bit),
    .pix_o         (demux_pix)
  );

  n64_vinfo #(
    .PAL_LINE_THRESHOLD (PAL_LINE_THRESHOLD)
  ) u_vinfo (
    .N64_CLK_i (N64_CLK_i),
    .rst_i     (rst_i),
    .pix_i     (demux_pix),
    .status_o  (PPUState_o)
  );

  // ==============================
  // processing
  // ==============================
  ppu_cfg_decode u_cfg_decode (
    .N64_CLK_i      (N64_CLK_i),
    .rst_i          (rst_i),
    .cfg_i          (ConfigSet_i),
    .n64_480i_i     (PPUState_o.n64_480i),
    .sl_en_o        (sl_en),
    .sl_str_o       (sl_str),
    .color_16bit_o  (color_16bit),
    .active_vsync_o (active_vsync),
    .active_hsync_o (active_hsync)
  );

  scanline_emu u_scanline_emu (
    .N64_CLK_i (N64_CLK_i),
    .rst_i     (rst_i),
    .sl_en_i   (sl_en),
    .sl_str_i  (sl_str),
    .pix_i     (demux_pix),
    .pix_o     (sl_pix)
  );

  // ==============================
  // output side
  // ==============================
  video_out u_video_out (
    .N64_CLK_i      (N64_CLK_i),
    .rst_i          (rst_i),
    .active_vsync_i (active_vsync),
    .active_hsync_i (active_hsync),
    .pix_i          (sl_pix),
    .VSYNC_o        (VSYNC_o),
    .HSYNC_o        (HSYNC_o),
    .DE_o           (DE_o),
    .VD_o           (VD_o)
  );

endmodule

`default_nettype wire

// File: verification/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;  // 10 ns period
  end

  // power-on reset, released on a falling edge
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

// File: verification/tb_n64_ppu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_n64_ppu;

  localparam int MAX_TESTS  = 16;
  localparam int RST_CYCLES = 5;

  typedef struct packed {
    logic        check;  // cleared while interlacing is not yet known
    logic [23:0] rgb;
  } exp_pix_t;

  logic                     clk;
  logic                     por_rst;
  logic                     test_rst;
  logic                     rst;
  logic                     nvdsync;
  n64_ppu_pkg::vd_in_t      vd;
  n64_ppu_pkg::ppu_cfg_t    cfg;
  n64_ppu_pkg::ppu_status_t status;
  logic                     vsync_out;
  logic                     hsync_out;
  logic                     de;
  logic [23:0]              vd_out;

  string                 names[MAX_TESTS];
  n64_ppu_pkg::ppu_cfg_t cfgs[MAX_TESTS];
  int                    lines_even[MAX_TESTS];
  int                    lines_odd[MAX_TESTS];
  int                    ppl[MAX_TESTS];
  int                    frames[MAX_TESTS];
  logic [2:0]            exp_status[MAX_TESTS];
  int                    num_tests;
  int                    budget;  // cycles for all tests
  string                 cur_name;
  exp_pix_t              exp_q[$];
  logic [31:0]           lfsr;
  int                    hs_cycles;
  int                    vs_cycles;

  assign rst = por_rst | test_rst;

  tb_clkgen #(.RESET_CYCLES(RST_CYCLES)) u_clkgen (.clk_o(clk), .rst_o(por_rst));

  n64_ppu_top #(
    .PAL_LINE_THRESHOLD (288)
  ) u_n64_ppu_top (
    .N64_CLK_i   (clk),
    .rst_i       (rst),
    .nVDSYNC_i   (nvdsync),
    .VD_i        (vd),
    .ConfigSet_i (cfg),
    .PPUState_o  (status),
    .VSYNC_o     (vsync_out),
    .HSYNC_o     (hsync_out),
    .DE_o        (de),
    .VD_o        (vd_out)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("Error in %s: %s expected %0h, actual %0h",
                          cur_name, what, expected, actual));
    end
  endtask

  // ==============================
  // stimulus and reference model
  // ==============================
  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr[0];
    lfsr = (lfsr >> 1) ^ (b ? 32'h80200003 : 32'h0);
    return b;
  endfunction

  function automatic logic [6:0] rand7();
    logic [6:0] v;
    for (int i = 0; i < 7; i++) begin
      v = {v[5:0], lfsr_bit()};
    end
    return v;
  endfunction

  // top bit repeated below the lsb
  function automatic logic [7:0] widen(input logic [6:0] c, input logic mode16);
    logic [6:0] m;
    m = mode16 ? (c & 7'h7c) : c;
    return {m, m[6]};
  endfunction

  function automatic logic [7:0] shade(input logic [7:0] c, input logic on, input int setting);
    int s;
    s = (setting + 1) * 16 - 1;
    return on ? 8'(int'(c) - int'(c) * s / 256) : c;
  endfunction

  // vsync_n on bit 3 and hsync_n on bit 1, other bits unused
  function automatic logic [6:0] sync_word(input logic vs_n, input logic hs_n);
    return {3'b010, vs_n, 1'b1, hs_n, 1'b1};
  endfunction

  task automatic drive_word(input logic nsync, input logic [6:0] w);
    @(negedge clk);
    nvdsync = nsync;
    vd      = w;
  endtask

  task automatic drive_frame(input int t, input int f);
    int         n_lines;
    logic       interlaced;
    logic       dim;
    logic       m16;
    logic [6:0] r;
    logic [6:0] g;
    logic [6:0] b;
    exp_pix_t   e;
    n_lines    = (f % 2 == 0) ? lines_even[t] : lines_odd[t];
    interlaced = (lines_even[t] % 2) != (lines_odd[t] % 2);
    m16        = cfgs[t].color_16bit;
    for (int ln = 0; ln < n_lines; ln++) begin
      drive_word(1'b0, sync_word(ln != 0, 1'b0));
      repeat (3) drive_word(1'b1, 7'h00);  // blank triple under hsync
      // interlacing is known from the third vsync on
      dim = cfgs[t].sl_en && (ln % 2 == 1) && !(interlaced && f >= 2);
      for (int p = 0; p < ppl[t]; p++) begin
        r = rand7();
        g = rand7();
        b = rand7();
        e.check = !(interlaced && cfgs[t].sl_en && f < 2);
        e.rgb   = {shade(widen(r, m16), dim, int'(cfgs[t].sl_str)),
                   shade(widen(g, m16), dim, int'(cfgs[t].sl_str)),
                   shade(widen(b, m16), dim, int'(cfgs[t].sl_str))};
        exp_q.push_back(e);
        drive_word(1'b0, sync_word(1'b1, 1'b1));
        drive_word(1'b1, r);
        drive_word(1'b1, g);
        drive_word(1'b1, b);
      end
    end
  endtask

  task automatic run_test(input int t);
    int total_lines;
    cur_name = names[t];
    @(negedge clk);
    test_rst = 1'b1;
    @(negedge clk);
    cfg     = cfgs[t];
    nvdsync = 1'b1;
    vd      = '0;
    repeat (RST_CYCLES) @(negedge clk);
    check_value("status in reset", 0, 32'(status));
    check_value("vsync idle", 32'(!cfg.active_vsync), 32'(vsync_out));
    check_value("hsync idle", 32'(!cfg.active_hsync), 32'(hsync_out));
    check_value("de in reset", 0, 32'(de));
    hs_cycles   = 0;
    vs_cycles   = 0;
    total_lines = 0;
    test_rst    = 1'b0;
    for (int f = 0; f < frames[t]; f++) begin
      drive_frame(t, f);
      total_lines += (f % 2 == 0) ? lines_even[t] : lines_odd[t];
    end
    drive_word(1'b1, 7'h00);  // bus idle
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    // each sync flag lasts one sync word plus one triple
    check_value("hsync cycles", 4 * total_lines, hs_cycles);
    check_value("vsync cycles", 4 * frames[t], vs_cycles);
    check_value("status", 32'(exp_status[t]), 32'(status));
  endtask

  // ==============================
  // output monitor
  // ==============================
  always @(negedge clk) begin : monitor
    exp_pix_t e;
    if (!rst) begin
      if (de) begin
        if (exp_q.size() == 0) begin
          abort_run("DE_o went high while no pixel was expected");
        end else begin
          e = exp_q.pop_front();
          if (e.check) begin
            check_value("pixel", 32'(e.rgb), 32'(vd_out));
          end
        end
      end else begin
        check_value("vd while blank", 0, 32'(vd_out));
      end
      if (hsync_out == cfg.active_hsync) begin
        hs_cycles++;
        check_value("de during hsync", 0, 32'(de));
      end
      if (vsync_out == cfg.active_vsync) begin
        vs_cycles++;
        check_value("de during vsync", 0, 32'(de));
      end
    end
  end

  initial begin : watchdog
    wait (budget > 0);
    repeat (2 * budget) @(posedge clk);
    abort_run("Timeout: the tests did not finish within the cycle budget");
  end

  initial begin : main
    int          fd;
    int          code;
    int          n;
    string       line;
    string       name;
    logic [15:0] cv;
    int          le;
    int          lo;
    int          pp;
    int          fr;
    logic [2:0]  st;
    nvdsync   = 1'b1;
    vd        = '0;
    cfg       = '0;
    test_rst  = 1'b0;
    lfsr      = 32'h7df04849;
    num_tests = 0;
    budget    = 0;
    fd = $fopen("verification/ppu_test_input.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open verification/ppu_test_input.txt");
    end
    while (!$feof(fd) && num_tests < MAX_TESTS) begin
      code = $fgets(line, fd);
      if (code > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %h %d %d %d %d %b", name, cv, le, lo, pp, fr, st);
        if (n == 7) begin
          names[num_tests]      = name;
          cfgs[num_tests]       = cv;
          lines_even[num_tests] = le;
          lines_odd[num_tests]  = lo;
          ppl[num_tests]        = pp;
          frames[num_tests]     = fr;
          exp_status[num_tests] = st;
          num_tests++;
          budget += ((fr + 1) / 2 * le + fr / 2 * lo) * (4 + 4 * pp) + RST_CYCLES + 16;
        end
      end
    end
    $fclose(fd);
    if (num_tests == 0) begin
      abort_run("No tests found in the test input file");
    end
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    cur_name = "end of run";
    check_value("pixels left in queue", 0, exp_q.size());
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/ppu_test_input.txt
# name  config(hex)  lines_even  lines_odd  pixels_per_line  frames  status(det,pal,480i)
# config bits: 15 sl_en, 14:11 sl_str, 10 color_16bit, 9 active_vsync, 8 active_hsync
demux_plain       0300  262  262  8  2  100
mode16            0700  262  262  6  2  100
sl_str0           8300  262  262  6  3  100
sl_str15          fb00  262  262  6  2  100
sl_mode16         bf5a  262  262  4  2  100
pal_status        0300  313  313  2  3  110
interlace_status  0300  262  263  2  4  101
pal_interlaced    0300  313  312  2  3  111
interlace_mask    fb00  262  263  4  4  101
sync_low          0000  262  262  2  2  100
sync_vs_high      0200  262  262  2  2  100
sync_hs_high      0100  262  262  2  2  100

// File: flist.f
rtl/n64_ppu_pkg.sv
rtl/n64_vdemux.sv
rtl/n64_vinfo.sv
rtl/ppu_cfg_decode.sv
rtl/scanline_emu.sv
rtl/video_out.sv
rtl/n64_ppu_top.sv
verification/tb_clkgen.sv
verification/tb_n64_ppu.sv

// File: Makefile
sim:
	verilator --binary --timing --assert -f flist.f --top-module tb_n64_ppu -o tb_n64_ppu
	./obj_dir/tb_n64_ppu

clean:
	rm -rf obj_dir

.PHONY: sim clean
